// ==== hdl/ex_consts.svh ====
// sizing macros for the execute stage; byte lanes and replication assume a 32-bit data path
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// data path width
`define EX_XLEN 32

// register file address width
`define EX_REG_AW 5

// one strobe bit per byte lane
`define EX_STRB_W 4

// iteration count of the radix-2 divider, one quotient bit per cycle
`define EX_DIV_CYCLES 32

`endif

// ==== hdl/ex_pkg.sv ====
// shared enums for the execute stage; opcode encodings are internal and not tied to any ISA
package ex_pkg;

    // operation codes carried from decode
    typedef enum logic [4:0] {
        op_add, op_sub, op_and, op_or, op_xor,
        op_sll, op_srl, op_sra, op_slt, op_sltu,
        op_div, op_divu, op_mod, op_modu,
        op_ld_b, op_ld_h, op_ld_w,
        op_st_b, op_st_h, op_st_w,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_b, op_jirl
    } ex_op_e;

    // data memory access size
    typedef enum logic [1:0] {
        mem_byte = 2'd0,
        mem_half = 2'd1,
        mem_word = 2'd2
    } mem_size_e;

    // divider control states
    typedef enum logic [1:0] {
        div_idle,
        div_busy,
        div_done
    } div_state_e;

endpackage

// ==== hdl/ex_div_if.sv ====
// stage to divider link; start is a single-cycle pulse and results hold until the next start or kill
`include "ex_consts.svh"

interface ex_div_if;
    logic                start;
    logic                kill;
    logic                is_signed;
    logic [`EX_XLEN-1:0] dividend;
    logic [`EX_XLEN-1:0] divisor;
    logic                done;
    logic [`EX_XLEN-1:0] quotient;
    logic [`EX_XLEN-1:0] remainder;

    // stage side
    modport requester (output start, kill, is_signed, dividend, divisor,
                       input  done, quotient, remainder);

    // divider side
    modport divider (input  start, kill, is_signed, dividend, divisor,
                     output done, quotient, remainder);
endinterface

// ==== hdl/ex_alu.sv ====
// single-cycle integer ALU; non-ALU opcodes give zero and shifts use only b_i[4:0]
`include "ex_consts.svh"

module ex_alu (
    input  ex_pkg::ex_op_e      op_i,
    input  logic [`EX_XLEN-1:0] a_i,
    input  logic [`EX_XLEN-1:0] b_i,
    output logic [`EX_XLEN-1:0] result_o
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b_i[4:0];
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (op_i)
            ex_pkg::op_add: begin
                result_o = a_i + b_i;
            end
            ex_pkg::op_sub: begin
                result_o = a_i - b_i;
            end
            ex_pkg::op_and: begin
                result_o = a_i & b_i;
            end
            ex_pkg::op_or: begin
                result_o = a_i | b_i;
            end
            ex_pkg::op_xor: begin
                result_o = a_i ^ b_i;
            end
            ex_pkg::op_sll: begin
                result_o = a_i << shamt;
            end
            ex_pkg::op_srl: begin
                result_o = a_i >> shamt;
            end
            // arithmetic shift keeps the sign bit
            ex_pkg::op_sra: begin
                result_o = $signed(a_i) >>> shamt;
            end
            ex_pkg::op_slt: begin
                result_o = {{(`EX_XLEN-1){1'b0}}, lt_signed};
            end
            ex_pkg::op_sltu: begin
                result_o = {{(`EX_XLEN-1){1'b0}}, lt_unsigned};
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

// ==== hdl/ex_divider.sv ====
// radix-2 restoring divider; done rises EX_DIV_CYCLES+1 cycles after start, kill drops back to idle
`include "ex_consts.svh"

module ex_divider (
    input  logic clk,
    input  logic rst_n_i,
    ex_div_if.divider div
);

    localparam int CNT_W = $clog2(`EX_DIV_CYCLES);

    ex_pkg::div_state_e  state;
    logic [CNT_W-1:0]    count;
    logic [`EX_XLEN-1:0] rem_r;
    logic [`EX_XLEN-1:0] quo_r;
    logic [`EX_XLEN-1:0] dvsr_r;
    logic                q_neg;
    logic                r_neg;
    logic                by_zero;
    logic                a_neg;
    logic                b_neg;
    logic [`EX_XLEN-1:0] a_mag;
    logic [`EX_XLEN-1:0] b_mag;
    logic [`EX_XLEN:0]   partial;
    logic [`EX_XLEN:0]   diff;

    // operand magnitudes, sign only matters for signed ops
    assign a_neg = div.is_signed & div.dividend[`EX_XLEN-1];
    assign b_neg = div.is_signed & div.divisor[`EX_XLEN-1];
    assign a_mag = a_neg ? -div.dividend : div.dividend;
    assign b_mag = b_neg ? -div.divisor : div.divisor;

    // shift in next dividend bit, trial subtract
    assign partial = {rem_r, quo_r[`EX_XLEN-1]};
    assign diff    = partial - {1'b0, dvsr_r};

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state <= ex_pkg::div_idle;
            count <= '0;
        end else if (div.kill) begin
            state <= ex_pkg::div_idle;
        end else if (div.start) begin
            state <= ex_pkg::div_busy;
            count <= '0;
        end else if (state == ex_pkg::div_busy) begin
            count <= count + 1'b1;
            if (count == CNT_W'(`EX_DIV_CYCLES - 1)) begin
                state <= ex_pkg::div_done;
            end
        end
    end

    // quotient bits shift in from the right as dividend bits leave
    always_ff @(posedge clk) begin
        if (div.start) begin
            rem_r   <= '0;
            quo_r   <= a_mag;
            dvsr_r  <= b_mag;
            q_neg   <= a_neg ^ b_neg;
            r_neg   <= a_neg;
            by_zero <= (div.divisor == '0);
        end else if (state == ex_pkg::div_busy) begin
            if (!diff[`EX_XLEN]) begin
                rem_r <= diff[`EX_XLEN-1:0];
                quo_r <= {quo_r[`EX_XLEN-2:0], 1'b1};
            end else begin
                rem_r <= partial[`EX_XLEN-1:0];
                quo_r <= {quo_r[`EX_XLEN-2:0], 1'b0};
            end
        end
    end

    assign div.done      = (state == ex_pkg::div_done);
    // remainder follows the dividend sign, which already yields the dividend on a zero divisor
    assign div.quotient  = by_zero ? '1 : (q_neg ? -quo_r : quo_r);
    assign div.remainder = r_neg ? -rem_r : rem_r;

    // the stage must wait for done before issuing again
    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
        div.start |-> state != ex_pkg::div_busy);

endmodule

// ==== hdl/ex_lsu_req.sv ====
// data memory request builder; misaligned accesses raise ale_o and never issue a request
`include "ex_consts.svh"

module ex_lsu_req (
    input  logic                  issue_i,
    input  ex_pkg::ex_op_e        op_i,
    input  logic [`EX_XLEN-1:0]   base_i,
    input  logic [`EX_XLEN-1:0]   offs_i,
    input  logic [`EX_XLEN-1:0]   store_data_i,
    output logic                  req_o,
    output logic                  we_o,
    output ex_pkg::mem_size_e     size_o,
    output logic [`EX_STRB_W-1:0] wstrb_o,
    output logic [`EX_XLEN-1:0]   addr_o,
    output logic [`EX_XLEN-1:0]   wdata_o,
    output logic                  ale_o
);

    logic                  is_load;
    logic                  is_store;
    logic                  misaligned;
    logic [`EX_STRB_W-1:0] lane_mask;

    assign is_load  = op_i inside {ex_pkg::op_ld_b, ex_pkg::op_ld_h, ex_pkg::op_ld_w};
    assign is_store = op_i inside {ex_pkg::op_st_b, ex_pkg::op_st_h, ex_pkg::op_st_w};
    assign addr_o   = base_i + offs_i;

    // size, lane mask, alignment and store data per access width
    always_comb begin
        case (op_i)
            ex_pkg::op_ld_b, ex_pkg::op_st_b: begin
                size_o     = ex_pkg::mem_byte;
                misaligned = 1'b0;
                lane_mask  = `EX_STRB_W'(1) << addr_o[1:0];
                wdata_o    = {4{store_data_i[7:0]}};
            end
            ex_pkg::op_ld_h, ex_pkg::op_st_h: begin
                size_o     = ex_pkg::mem_half;
                misaligned = addr_o[0];
                lane_mask  = addr_o[1] ? 4'b1100 : 4'b0011;
                wdata_o    = {2{store_data_i[15:0]}};
            end
            default: begin
                size_o     = ex_pkg::mem_word;
                misaligned = |addr_o[1:0];
                lane_mask  = '1;
                wdata_o    = store_data_i;
            end
        endcase
    end

    assign ale_o   = (is_load | is_store) & misaligned;
    assign we_o    = is_store;
    assign req_o   = issue_i & (is_load | is_store) & ~misaligned;
    // loads and misaligned stores leave every lane off
    assign wstrb_o = (is_store & ~misaligned) ? lane_mask : '0;

    always_comb begin
        a_strb_store: assert final (wstrb_o == '0 || (we_o && !ale_o));
    end

endmodule

// ==== hdl/ex_branch.sv ====
// branch resolution; offsets arrive pre-scaled and sign-extended, link is always pc+4
`include "ex_consts.svh"

module ex_branch (
    input  ex_pkg::ex_op_e      op_i,
    input  logic [`EX_XLEN-1:0] pc_i,
    input  logic [`EX_XLEN-1:0] rj_i,
    input  logic [`EX_XLEN-1:0] rd_i,
    input  logic [`EX_XLEN-1:0] offs_i,
    output logic                taken_o,
    output logic [`EX_XLEN-1:0] target_o,
    output logic [`EX_XLEN-1:0] link_o
);

    logic [`EX_XLEN-1:0] base;

    always_comb begin
        case (op_i)
            ex_pkg::op_beq:  taken_o = (rj_i == rd_i);
            ex_pkg::op_bne:  taken_o = (rj_i != rd_i);
            ex_pkg::op_blt:  taken_o = ($signed(rj_i) < $signed(rd_i));
            ex_pkg::op_bge:  taken_o = ($signed(rj_i) >= $signed(rd_i));
            ex_pkg::op_bltu: taken_o = (rj_i < rd_i);
            ex_pkg::op_bgeu: taken_o = (rj_i >= rd_i);
            // unconditional
            ex_pkg::op_b, ex_pkg::op_jirl: begin
                taken_o = 1'b1;
            end
            default: begin
                taken_o = 1'b0;
            end
        endcase
    end

    // jirl is register relative, everything else pc relative
    assign base     = (op_i == ex_pkg::op_jirl) ? rj_i : pc_i;
    assign target_o = base + offs_i;
    assign link_o   = pc_i + `EX_XLEN'(4);

endmodule

// ==== hdl/ex_stage.sv ====
// execute stage top; rj is in_oper1_i and serves as load/store base, flush_i also blocks capture
`include "ex_consts.svh"

module ex_stage (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  logic                  in_valid_i,
    input  ex_pkg::ex_op_e        in_op_i,
    input  logic [`EX_XLEN-1:0]   in_pc_i,
    input  logic [`EX_XLEN-1:0]   in_oper1_i,
    input  logic [`EX_XLEN-1:0]   in_oper2_i,
    input  logic [`EX_XLEN-1:0]   in_store_data_i,
    input  logic [`EX_XLEN-1:0]   in_offs_i,
    input  logic [`EX_REG_AW-1:0] in_rd_i,
    input  logic                  in_rd_we_i,
    input  logic                  next_allowin_i,
    input  logic                  dmem_addr_ok_i,
    output logic                  in_allowin_o,
    output logic                  out_valid_o,
    output logic [`EX_XLEN-1:0]   out_pc_o,
    output ex_pkg::ex_op_e        out_op_o,
    output logic [`EX_REG_AW-1:0] out_rd_o,
    output logic                  out_rd_we_o,
    output logic [`EX_XLEN-1:0]   out_result_o,
    output logic                  out_ale_o,
    output logic                  dmem_req_o,
    output logic                  dmem_we_o,
    output ex_pkg::mem_size_e     dmem_size_o,
    output logic [`EX_STRB_W-1:0] dmem_wstrb_o,
    output logic [`EX_XLEN-1:0]   dmem_addr_o,
    output logic [`EX_XLEN-1:0]   dmem_wdata_o,
    output logic                  branch_flush_o,
    output logic [`EX_XLEN-1:0]   branch_target_o
);

    logic                  stage_valid;
    logic                  div_issued;
    ex_pkg::ex_op_e        op_r;
    logic [`EX_XLEN-1:0]   pc_r;
    logic [`EX_XLEN-1:0]   oper1_r;
    logic [`EX_XLEN-1:0]   oper2_r;
    logic [`EX_XLEN-1:0]   sdata_r;
    logic [`EX_XLEN-1:0]   offs_r;
    logic [`EX_REG_AW-1:0] rd_r;
    logic                  rd_we_r;
    logic                  is_div;
    logic                  is_mem;
    logic                  is_cond_br;
    logic                  ready_go;
    logic                  transfer;
    logic                  br_taken;
    logic [`EX_XLEN-1:0]   alu_result;
    logic [`EX_XLEN-1:0]   link;

    ex_div_if div_bus ();

    ex_alu u_alu (.op_i(op_r), .a_i(oper1_r), .b_i(oper2_r), .result_o(alu_result));

    ex_divider u_div (.clk(clk), .rst_n_i(rst_n_i), .div(div_bus));

    ex_lsu_req u_lsu (
        .issue_i     (stage_valid & next_allowin_i & ~flush_i),
        .op_i        (op_r),
        .base_i      (oper1_r),
        .offs_i      (offs_r),
        .store_data_i(sdata_r),
        .req_o       (dmem_req_o),
        .we_o        (dmem_we_o),
        .size_o      (dmem_size_o),
        .wstrb_o     (dmem_wstrb_o),
        .addr_o      (dmem_addr_o),
        .wdata_o     (dmem_wdata_o),
        .ale_o       (out_ale_o)
    );

    ex_branch u_br (
        .op_i    (op_r),
        .pc_i    (pc_r),
        .rj_i    (oper1_r),
        .rd_i    (oper2_r),
        .offs_i  (offs_r),
        .taken_o (br_taken),
        .target_o(branch_target_o),
        .link_o  (link)
    );

    assign is_div     = op_r inside {ex_pkg::op_div, ex_pkg::op_divu,
                                     ex_pkg::op_mod, ex_pkg::op_modu};
    assign is_mem     = op_r inside {ex_pkg::op_ld_b, ex_pkg::op_ld_h, ex_pkg::op_ld_w,
                                     ex_pkg::op_st_b, ex_pkg::op_st_h, ex_pkg::op_st_w};
    assign is_cond_br = op_r inside {ex_pkg::op_beq, ex_pkg::op_bne, ex_pkg::op_blt,
                                     ex_pkg::op_bge, ex_pkg::op_bltu, ex_pkg::op_bgeu};

    // divider is issued once per instruction, killed on flush
    assign div_bus.start     = stage_valid & is_div & ~div_issued & ~flush_i;
    assign div_bus.kill      = flush_i;
    assign div_bus.is_signed = (op_r == ex_pkg::op_div) | (op_r == ex_pkg::op_mod);
    assign div_bus.dividend  = oper1_r;
    assign div_bus.divisor   = oper2_r;

    // memory ops finish on address accept, misaligned ones at once
    always_comb begin
        if (is_div) begin
            ready_go = div_issued & div_bus.done;
        end else if (is_mem & ~out_ale_o) begin
            ready_go = dmem_req_o & dmem_addr_ok_i;
        end else begin
            ready_go = 1'b1;
        end
    end

    assign out_valid_o    = stage_valid & ready_go & ~flush_i;
    assign in_allowin_o   = ~flush_i & (~stage_valid | (ready_go & next_allowin_i));
    assign transfer       = out_valid_o & next_allowin_i;
    assign branch_flush_o = transfer & br_taken;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            stage_valid <= 1'b0;
            div_issued  <= 1'b0;
        end else if (flush_i) begin
            stage_valid <= 1'b0;
            div_issued  <= 1'b0;
        end else begin
            if (in_allowin_o) begin
                stage_valid <= in_valid_i;
            end
            if (div_bus.start) begin
                div_issued <= 1'b1;
            end else if (transfer) begin
                div_issued <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_allowin_o && in_valid_i) begin
            op_r    <= in_op_i;
            pc_r    <= in_pc_i;
            oper1_r <= in_oper1_i;
            oper2_r <= in_oper2_i;
            sdata_r <= in_store_data_i;
            offs_r  <= in_offs_i;
            rd_r    <= in_rd_i;
            rd_we_r <= in_rd_we_i;
        end
    end

    always_comb begin
        case (op_r)
            ex_pkg::op_div, ex_pkg::op_divu:                   out_result_o = div_bus.quotient;
            ex_pkg::op_mod, ex_pkg::op_modu:                   out_result_o = div_bus.remainder;
            ex_pkg::op_ld_b, ex_pkg::op_ld_h, ex_pkg::op_ld_w: out_result_o = dmem_addr_o;
            ex_pkg::op_b, ex_pkg::op_jirl:                     out_result_o = link;
            default:                                           out_result_o = alu_result;
        endcase
    end

    assign out_pc_o    = pc_r;
    assign out_op_o    = op_r;
    assign out_rd_o    = rd_r;
    // no writeback for stores, conditional branches or faulting accesses
    assign out_rd_we_o = rd_we_r & ~dmem_we_o & ~is_cond_br & ~out_ale_o;

    a_flush_on_xfer: assert property (@(posedge clk) disable iff (!rst_n_i)
        branch_flush_o |-> out_valid_o && next_allowin_i);

    a_empty_quiet: assert property (@(posedge clk) disable iff (!rst_n_i)
        !stage_valid |-> !out_valid_o && !dmem_req_o);

    // a stalled result stays offered, the divider must hold done
    a_hold_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        out_valid_o && !next_allowin_i && !flush_i |=> out_valid_o || flush_i);

endmodule

// ==== test/tb_ex_stage.sv ====
// random-stimulus testbench for ex_stage; holds at most one instruction in flight, op order from ex_pkg
`include "ex_consts.svh"

module tb_ex_stage;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_INSTR    = 400;
    localparam int CLK_PERIOD = 4;

    // expected response of one captured instruction
    typedef struct packed {
        logic [`EX_XLEN-1:0]   pc;
        ex_pkg::ex_op_e        op;
        logic [`EX_REG_AW-1:0] rd;
        logic [`EX_XLEN-1:0]   result;
        logic [`EX_XLEN-1:0]   addr;
        logic [`EX_XLEN-1:0]   wdata;
        logic [`EX_XLEN-1:0]   target;
        logic [`EX_STRB_W-1:0] wstrb;
        ex_pkg::mem_size_e     size;
        logic                  rd_we;
        logic                  chk_res;
        logic                  ale;
        logic                  we;
        logic                  req_ok;
        logic                  taken;
        logic                  fixed;
    } exp_t;

    logic                  clk = 1'b0;
    logic                  rst_n_i;
    logic                  flush_i;
    logic                  in_valid_i;
    ex_pkg::ex_op_e        in_op_i;
    logic [`EX_XLEN-1:0]   in_pc_i;
    logic [`EX_XLEN-1:0]   in_oper1_i;
    logic [`EX_XLEN-1:0]   in_oper2_i;
    logic [`EX_XLEN-1:0]   in_store_data_i;
    logic [`EX_XLEN-1:0]   in_offs_i;
    logic [`EX_REG_AW-1:0] in_rd_i;
    logic                  in_rd_we_i;
    logic                  next_allowin_i;
    logic                  dmem_addr_ok_i;
    logic                  in_allowin_o;
    logic                  out_valid_o;
    logic [`EX_XLEN-1:0]   out_pc_o;
    ex_pkg::ex_op_e        out_op_o;
    logic [`EX_REG_AW-1:0] out_rd_o;
    logic                  out_rd_we_o;
    logic [`EX_XLEN-1:0]   out_result_o;
    logic                  out_ale_o;
    logic                  dmem_req_o;
    logic                  dmem_we_o;
    ex_pkg::mem_size_e     dmem_size_o;
    logic [`EX_STRB_W-1:0] dmem_wstrb_o;
    logic [`EX_XLEN-1:0]   dmem_addr_o;
    logic [`EX_XLEN-1:0]   dmem_wdata_o;
    logic                  branch_flush_o;
    logic [`EX_XLEN-1:0]   branch_target_o;

    exp_t exp_q[$];
    exp_t cur       = '0;
    logic cur_valid = 1'b0;
    logic took      = 1'b0;
    int   sent      = 0;
    int   xfers     = 0;
    int   flushes   = 0;
    int   errors    = 0;

    ex_stage dut_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_value(input string name, input logic [`EX_XLEN-1:0] expected,
                                input logic [`EX_XLEN-1:0] actual);
        errors++;
        $display("ERROR %0d ns: %s expected %h, got %h", $time, name, expected, actual);
    endtask

    task automatic report_fault(input string what);
        errors++;
        $display("at %0d ns: %s", $time, what);
    endtask

    // {quotient, remainder} straight from the arithmetic rules
    function automatic logic [2*`EX_XLEN-1:0] divide_ref(input logic sgn,
            input logic [`EX_XLEN-1:0] a, input logic [`EX_XLEN-1:0] b);
        logic [`EX_XLEN-1:0] min_int;
        min_int = {1'b1, {(`EX_XLEN-1){1'b0}}};
        if (b == '0) begin
            return {{`EX_XLEN{1'b1}}, a};
        end
        if (sgn && a == min_int && b == '1) begin
            return {min_int, {`EX_XLEN{1'b0}}};
        end
        if (sgn) begin
            return {$signed(a) / $signed(b), $signed(a) % $signed(b)};
        end
        return {a / b, a % b};
    endfunction

    function automatic exp_t predict(input ex_pkg::ex_op_e op, input logic [`EX_XLEN-1:0] pc,
            input logic [`EX_XLEN-1:0] a, input logic [`EX_XLEN-1:0] b,
            input logic [`EX_XLEN-1:0] sd, input logic [`EX_XLEN-1:0] offs,
            input logic [`EX_REG_AW-1:0] rd, input logic rd_we);
        exp_t                  e;
        logic [2*`EX_XLEN-1:0] qr;
        logic                  is_ld;
        logic                  is_st;
        logic                  is_div;
        logic                  is_cond;
        e         = '0;
        e.pc      = pc;
        e.op      = op;
        e.rd      = rd;
        e.addr    = a + offs;
        e.target  = ((op == ex_pkg::op_jirl) ? a : pc) + offs;
        e.rd_we   = rd_we;
        e.chk_res = 1'b1;
        is_ld     = op inside {ex_pkg::op_ld_b, ex_pkg::op_ld_h, ex_pkg::op_ld_w};
        is_st     = op inside {ex_pkg::op_st_b, ex_pkg::op_st_h, ex_pkg::op_st_w};
        is_div    = op inside {ex_pkg::op_div, ex_pkg::op_divu, ex_pkg::op_mod, ex_pkg::op_modu};
        is_cond   = op inside {ex_pkg::op_beq, ex_pkg::op_bne, ex_pkg::op_blt,
                               ex_pkg::op_bge, ex_pkg::op_bltu, ex_pkg::op_bgeu};
        qr        = divide_ref(op == ex_pkg::op_div || op == ex_pkg::op_mod, a, b);
        case (op)
            ex_pkg::op_add:  e.result = a + b;
            ex_pkg::op_sub:  e.result = a - b;
            ex_pkg::op_and:  e.result = a & b;
            ex_pkg::op_or:   e.result = a | b;
            ex_pkg::op_xor:  e.result = a ^ b;
            ex_pkg::op_sll:  e.result = a << b[4:0];
            ex_pkg::op_srl:  e.result = a >> b[4:0];
            ex_pkg::op_sra:  e.result = $signed(a) >>> b[4:0];
            ex_pkg::op_slt:  e.result = `EX_XLEN'($signed(a) < $signed(b));
            ex_pkg::op_sltu: e.result = `EX_XLEN'(a < b);
            ex_pkg::op_div, ex_pkg::op_divu: e.result = qr[2*`EX_XLEN-1:`EX_XLEN];
            ex_pkg::op_mod, ex_pkg::op_modu: e.result = qr[`EX_XLEN-1:0];
            ex_pkg::op_ld_b, ex_pkg::op_st_b: begin
                e.size  = ex_pkg::mem_byte;
                e.wstrb = 4'b0001 << e.addr[1:0];
                e.wdata = {4{sd[7:0]}};
            end
            ex_pkg::op_ld_h, ex_pkg::op_st_h: begin
                e.size  = ex_pkg::mem_half;
                e.ale   = e.addr[0];
                e.wstrb = 4'b0011 << {e.addr[1], 1'b0};
                e.wdata = {2{sd[15:0]}};
            end
            ex_pkg::op_ld_w, ex_pkg::op_st_w: begin
                e.size  = ex_pkg::mem_word;
                e.ale   = |e.addr[1:0];
                e.wstrb = 4'b1111;
                e.wdata = sd;
            end
            ex_pkg::op_beq:  e.taken = (a == b);
            ex_pkg::op_bne:  e.taken = (a != b);
            ex_pkg::op_blt:  e.taken = ($signed(a) < $signed(b));
            ex_pkg::op_bge:  e.taken = ($signed(a) >= $signed(b));
            ex_pkg::op_bltu: e.taken = (a < b);
            ex_pkg::op_bgeu: e.taken = (a >= b);
            // b and jirl
            default: begin
                e.taken  = 1'b1;
                e.result = pc + 4;
            end
        endcase
        if (is_ld) begin
            e.result = e.addr;
        end
        if (!is_st) begin
            e.wstrb = '0;
        end
        e.we      = is_st;
        e.req_ok  = (is_ld || is_st) && !e.ale;
        e.fixed   = !e.req_ok && !is_div;
        e.chk_res = !is_st && !is_cond;
        if (is_st || is_cond || e.ale) begin
            e.rd_we = 1'b0;
        end
        return e;
    endfunction

    task automatic make_instr();
        logic [2:0] pick;
        pick = 3'($urandom_range(7, 0));
        // division opcodes 10..13 get extra weight
        if ($urandom_range(3, 0) == 0) begin
            in_op_i = ex_pkg::ex_op_e'(5'($urandom_range(13, 10)));
        end else begin
            in_op_i = ex_pkg::ex_op_e'(5'($urandom_range(27, 0)));
        end
        in_pc_i         = $urandom & 32'hffff_fffc;
        in_oper1_i      = $urandom;
        in_oper2_i      = $urandom;
        in_store_data_i = $urandom;
        in_offs_i       = pick[0] ? `EX_XLEN'($urandom_range(15, 0)) : $urandom;
        in_rd_i         = `EX_REG_AW'($urandom);
        in_rd_we_i      = 1'($urandom);
        case (pick)
            3'd1: in_oper2_i = in_oper1_i;
            3'd2: in_oper2_i = '0;
            3'd3: begin
                in_oper1_i = 32'h8000_0000;
                in_oper2_i = '1;
            end
            // force an aligned address
            3'd4: begin
                in_oper1_i[1:0] = 2'b00;
                in_offs_i[1:0]  = 2'b00;
            end
            default: begin
            end
        endcase
    endtask

    task automatic drive_downstream();
        next_allowin_i = ($urandom_range(3, 0) != 0);
        dmem_addr_ok_i = ($urandom_range(2, 0) != 0);
        flush_i        = ($urandom_range(63, 0) == 0);
    endtask

    // occupancy model with one entry per captured instruction
    always @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            if (rst_n_i && exp_q.size() != 0) begin
                flushes++;
            end
            exp_q.delete();
        end else begin
            if (out_valid_o && next_allowin_i) begin
                void'(exp_q.pop_front());
                xfers++;
            end
            if (in_valid_i && in_allowin_o) begin
                exp_q.push_back(predict(in_op_i, in_pc_i, in_oper1_i, in_oper2_i,
                                        in_store_data_i, in_offs_i, in_rd_i, in_rd_we_i));
            end
        end
        took      <= rst_n_i && in_valid_i && in_allowin_o;
        cur_valid <= (exp_q.size() != 0);
        cur       <= (exp_q.size() != 0) ? exp_q[0] : '0;
    end

    a_valid_full: assert property (@(posedge clk) disable iff (!rst_n_i)
        out_valid_o |-> cur_valid)
        else report_fault("out_valid_o high while the stage is empty");

    // empty stage takes input, a full stalled one refuses it
    a_allowin: assert property (@(posedge clk) disable iff (!rst_n_i)
        !flush_i && (!cur_valid || !next_allowin_i) |-> in_allowin_o == !cur_valid)
        else report_value("in_allowin_o", `EX_XLEN'(!$sampled(cur_valid)),
                          `EX_XLEN'($sampled(in_allowin_o)));

    a_fixed_lat: assert property (@(posedge clk) disable iff (!rst_n_i)
        cur_valid && cur.fixed && !flush_i |-> out_valid_o)
        else report_fault("single-cycle instruction did not raise out_valid_o");

    a_pc: assert property (@(posedge clk) disable iff (!rst_n_i)
        out_valid_o |-> out_pc_o == cur.pc)
        else report_value("out_pc_o", $sampled(cur.pc), $sampled(out_pc_o));

    a_op: assert property (@(posedge clk) disable iff (!rst_n_i)
        out_valid_o |-> out_op_o == cur.op)
        else report_value("out_op_o", `EX_XLEN'($sampled(cur.op)),
                          `EX_XLEN'($sampled(out_op_o)));

    a_rd: assert property (@(posedge clk) disable iff (!rst_n_i)
        out_valid_o |-> out_rd_o == cur.rd)
        else report_value("out_rd_o", `EX_XLEN'($sampled(cur.rd)),
                          `EX_XLEN'($sampled(out_rd_o)));

    a_result: assert property (@(posedge clk) disable iff (!rst_n_i)
        out_valid_o && cur.chk_res |-> out_result_o == cur.result)
        else report_value("out_result_o", $sampled(cur.result), $sampled(out_result_o));

    a_rd_we: assert property (@(posedge clk) disable iff (!rst_n_i)
        out_valid_o |-> out_rd_we_o == cur.rd_we)
        else report_value("out_rd_we_o", `EX_XLEN'($sampled(cur.rd_we)),
                          `EX_XLEN'($sampled(out_rd_we_o)));

    a_ale: assert property (@(posedge clk) disable iff (!rst_n_i)
        out_valid_o |-> out_ale_o == cur.ale)
        else report_value("out_ale_o", `EX_XLEN'($sampled(cur.ale)),
                          `EX_XLEN'($sampled(out_ale_o)));

    a_req_legal: assert property (@(posedge clk) disable iff (!rst_n_i)
        dmem_req_o |-> cur_valid && cur.req_ok && next_allowin_i && !flush_i)
        else report_fault("dmem_req_o raised without an aligned access ready to leave");

    a_mem_accept: assert property (@(posedge clk) disable iff (!rst_n_i)
        cur_valid && cur.req_ok |-> out_valid_o == (dmem_req_o && dmem_addr_ok_i))
        else report_fault("out_valid_o of a memory access is not the accept cycle");

    a_addr: assert property (@(posedge clk) disable iff (!rst_n_i)
        dmem_req_o |-> dmem_addr_o == cur.addr)
        else report_value("dmem_addr_o", $sampled(cur.addr), $sampled(dmem_addr_o));

    a_size: assert property (@(posedge clk) disable iff (!rst_n_i)
        dmem_req_o |-> dmem_size_o == cur.size)
        else report_value("dmem_size_o", `EX_XLEN'($sampled(cur.size)),
                          `EX_XLEN'($sampled(dmem_size_o)));

    a_we: assert property (@(posedge clk) disable iff (!rst_n_i)
        dmem_req_o |-> dmem_we_o == cur.we)
        else report_value("dmem_we_o", `EX_XLEN'($sampled(cur.we)),
                          `EX_XLEN'($sampled(dmem_we_o)));

    a_wstrb: assert property (@(posedge clk) disable iff (!rst_n_i)
        dmem_req_o |-> dmem_wstrb_o == cur.wstrb)
        else report_value("dmem_wstrb_o", `EX_XLEN'($sampled(cur.wstrb)),
                          `EX_XLEN'($sampled(dmem_wstrb_o)));

    a_wdata: assert property (@(posedge clk) disable iff (!rst_n_i)
        dmem_req_o && cur.we |-> dmem_wdata_o == cur.wdata)
        else report_value("dmem_wdata_o", $sampled(cur.wdata), $sampled(dmem_wdata_o));

    a_taken: assert property (@(posedge clk) disable iff (!rst_n_i)
        out_valid_o && next_allowin_i |-> branch_flush_o == cur.taken)
        else report_value("branch_flush_o", `EX_XLEN'($sampled(cur.taken)),
                          `EX_XLEN'($sampled(branch_flush_o)));

    a_target: assert property (@(posedge clk) disable iff (!rst_n_i)
        branch_flush_o |-> branch_target_o == cur.target)
        else report_value("branch_target_o", $sampled(cur.target),
                          $sampled(branch_target_o));

    // stalled result must stay offered and unchanged
    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        out_valid_o && !next_allowin_i && !flush_i |=> (out_valid_o || flush_i)
            && $stable(out_result_o) && $stable(out_pc_o) && $stable(out_rd_we_o))
        else report_fault("outputs moved while next_allowin_i was low");

    a_flush_quiet: assert property (@(posedge clk) disable iff (!rst_n_i)
        flush_i |-> !out_valid_o && !dmem_req_o && !branch_flush_o)
        else report_fault("stage still active during flush_i");

    initial begin
        void'($urandom(32'he409));
        rst_n_i         = 1'b0;
        flush_i         = 1'b0;
        in_valid_i      = 1'b0;
        in_op_i         = ex_pkg::op_add;
        in_pc_i         = '0;
        in_oper1_i      = '0;
        in_oper2_i      = '0;
        in_store_data_i = '0;
        in_offs_i       = '0;
        in_rd_i         = '0;
        in_rd_we_i      = 1'b0;
        next_allowin_i  = 1'b0;
        dmem_addr_ok_i  = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        while (sent < N_INSTR) begin
            drive_downstream();
            // source holds an instruction until the stage takes it
            if (in_valid_i && took) begin
                sent++;
                in_valid_i = 1'b0;
            end
            if (!in_valid_i && sent < N_INSTR && $urandom_range(3, 0) != 0) begin
                make_instr();
                in_valid_i = 1'b1;
            end
            @(negedge clk);
        end
        // drain the last instruction
        flush_i        = 1'b0;
        next_allowin_i = 1'b1;
        dmem_addr_ok_i = 1'b1;
        while (cur_valid) begin
            @(negedge clk);
        end
        $display("instructions %0d, transfers %0d, flushed %0d, errors %0d",
                 sent, xfers, flushes, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // worst case is every instruction being a stalled division
    initial begin
        #(N_INSTR * (`EX_DIV_CYCLES + 20) * CLK_PERIOD);
        $display("timeout with %0d of %0d instructions taken, errors %0d",
                 sent, N_INSTR, errors);
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+hdl
hdl/ex_pkg.sv
hdl/ex_div_if.sv
hdl/ex_alu.sv
hdl/ex_divider.sv
hdl/ex_lsu_req.sv
hdl/ex_branch.sv
hdl/ex_stage.sv
test/tb_ex_stage.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and judge the result from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_ex_stage -f sources.f || exit 1
./obj_dir/Vtb_ex_stage > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log
grep -q "^Regression passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
